//--- sim.f
+incdir+verification
hw/ooo_types_pkg.sv
hw/ooo_ctrl_pkg.sv
hw/alias_table.sv
hw/reorder_buffer.sv
hw/arch_regfile.sv
hw/ooo_commit_top.sv
verification/tb_ooo_commit.sv

//--- Bender.yml
package:
  name: ooo_commit

sources:
  - files:
      - hw/ooo_types_pkg.sv
      - hw/ooo_ctrl_pkg.sv
      - hw/alias_table.sv
      - hw/reorder_buffer.sv
      - hw/arch_regfile.sv
      - hw/ooo_commit_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_ooo_commit.sv

//--- verification/tb_ooo_model.svh
`ifndef TB_OOO_MODEL_SVH
`define TB_OOO_MODEL_SVH

typedef struct packed {
    ooo_types_pkg::rob_tag_t tag;
    ooo_types_pkg::reg_idx_t rd;
    logic                    is_store;
    logic                    pred;
    logic                    done;
    ooo_types_pkg::data_t    data;
    logic                    actual;
    ooo_types_pkg::addr_t    target;
} model_entry_t;

// program order, oldest first
model_entry_t                 in_order [$];
ooo_types_pkg::data_t         model_regs [ooo_types_pkg::num_regs];
ooo_types_pkg::rob_tag_t      model_tail;
int                           credits;
int                           in_flight;
logic [15:0]                  lfsr_state;

// what the DUT should show after the coming edge
ooo_types_pkg::commit_t       exp_commit;
ooo_ctrl_pkg::store_release_t exp_store;
ooo_ctrl_pkg::redirect_t      exp_redirect;
ooo_ctrl_pkg::credit_t        exp_credit;
ooo_types_pkg::rob_tag_t      exp_alloc_tag;
ooo_types_pkg::operand_t      exp_src1;
ooo_types_pkg::operand_t      exp_src2;

// taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
endfunction

task automatic reset_model();
    in_order.delete();
    foreach (model_regs[i]) begin
        model_regs[i] = '0;
    end
    model_tail    = '0;
    credits       = ooo_ctrl_pkg::rob_depth;
    in_flight     = 0;
    lfsr_state    = 16'd59292;
    exp_commit    = '0;
    exp_store     = '0;
    exp_redirect  = '0;
    exp_credit    = '0;
    exp_alloc_tag = '0;
    exp_src1      = '{ready: 1'b1, tag: '0, value: '0};
    exp_src2      = exp_src1;
endtask

// youngest in-flight producer wins, last match in the queue
function automatic ooo_types_pkg::operand_t expect_operand(input ooo_types_pkg::reg_idx_t rs);
    ooo_types_pkg::operand_t op;
    op = '{ready: 1'b1, tag: '0, value: model_regs[rs]};
    foreach (in_order[i]) begin
        if ((rs != '0) && (in_order[i].rd == rs)) begin
            op.ready = in_order[i].done;
            op.tag   = in_order[i].tag;
            op.value = in_order[i].data;
        end
    end
    return op;
endfunction

task automatic apply_edge(input ooo_types_pkg::dispatch_t d, input ooo_types_pkg::complete_t c);
    model_entry_t head;
    model_entry_t fresh;
    logic         retire;
    logic         mispredict;
    head = '0;
    if (in_order.size() > 0) begin
        head = in_order[0];
    end
    // head must have been done before this edge
    retire     = (in_order.size() > 0) && head.done;
    mispredict = retire && (head.pred != head.actual);
    exp_commit   = '{valid: retire && !head.is_store, rd: head.rd, data: head.data,
                     tag: head.tag};
    exp_store    = '{valid: retire && head.is_store, tag: head.tag};
    exp_redirect = '{valid: mispredict, target: head.target};
    if (mispredict) begin
        exp_credit = ooo_ctrl_pkg::credit_t'(in_order.size() + int'(d.valid));
    end else begin
        exp_credit = ooo_ctrl_pkg::credit_t'(retire);
    end
    if (c.valid) begin
        foreach (in_order[i]) begin
            if (in_order[i].tag == c.tag) begin
                in_order[i].done   = 1'b1;
                in_order[i].data   = c.data;
                in_order[i].actual = c.actual_taken;
                in_order[i].target = c.target;
            end
        end
    end
    if (exp_commit.valid && (head.rd != '0)) begin
        model_regs[head.rd] = head.data;
    end
    if (mispredict) begin
        // same-edge dispatch is dropped with the rest
        in_order.delete();
        model_tail = head.tag + 1'b1;
    end else begin
        if (retire) begin
            void'(in_order.pop_front());
        end
        if (d.valid) begin
            fresh          = '0;
            fresh.tag      = model_tail;
            fresh.rd       = d.rd;
            fresh.is_store = d.is_store;
            fresh.pred     = d.pred_taken;
            in_order.push_back(fresh);
            model_tail = model_tail + 1'b1;
        end
    end
    in_flight     = in_order.size();
    exp_alloc_tag = model_tail;
    exp_src1      = expect_operand(d.rs1);
    exp_src2      = expect_operand(d.rs2);
endtask

`endif

//--- verification/tb_ooo_commit.sv
`timescale 1ns/10ps

module tb_ooo_commit;

    localparam int num_instr  = 400;
    // ten cycles per instruction
    localparam int max_cycles = num_instr * 10;

    logic                         clk;
    logic                         rst;
    ooo_types_pkg::dispatch_t     dispatch;
    ooo_types_pkg::complete_t     complete;
    ooo_types_pkg::rob_tag_t      alloc_tag;
    ooo_types_pkg::operand_t      src1;
    ooo_types_pkg::operand_t      src2;
    ooo_types_pkg::commit_t       commit;
    ooo_ctrl_pkg::store_release_t store_release;
    ooo_ctrl_pkg::redirect_t      redirect;
    ooo_ctrl_pkg::credit_t        credit_return;

    int dispatched;
    int cycles;

`include "tb_ooo_model.svh"

    ooo_commit_top ooo_commit_top_inst (
        .clk           (clk),
        .rst           (rst),
        .dispatch      (dispatch),
        .complete      (complete),
        .alloc_tag     (alloc_tag),
        .src1          (src1),
        .src2          (src2),
        .commit        (commit),
        .store_release (store_release),
        .redirect      (redirect),
        .credit_return (credit_return)
    );

    always #50 clk = ~clk;

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [71:0] expected,
                                   input logic [71:0] actual);
        $display("FAILED %0t %s expected %0h actual %0h", $time, name, expected, actual);
        stop_with_failure();
    endtask

    // tag only matters while pending
    function automatic logic operand_match(input ooo_types_pkg::operand_t a,
                                           input ooo_types_pkg::operand_t e);
        return (a.ready == e.ready) && (a.ready ? (a.value == e.value) : (a.tag == e.tag));
    endfunction

    function automatic ooo_types_pkg::dispatch_t pick_dispatch();
        ooo_types_pkg::dispatch_t d;
        d     = '0;
        d.rs1 = ooo_types_pkg::reg_idx_t'(rand_bits(3));
        d.rs2 = ooo_types_pkg::reg_idx_t'(rand_bits(3));
        if ((credits > 0) && (dispatched < num_instr) && (rand_bits(2) != 0)) begin
            d.valid      = 1'b1;
            d.is_store   = (rand_bits(3) == 0);
            // stores write no register
            d.rd         = d.is_store ? '0 : ooo_types_pkg::reg_idx_t'(rand_bits(3));
            d.pred_taken = (rand_bits(1) != 0);
        end
        return d;
    endfunction

    // any pending tag, out of order
    function automatic ooo_types_pkg::complete_t pick_completion();
        ooo_types_pkg::complete_t c;
        int                       pending [$];
        int                       idx;
        c = '0;
        foreach (in_order[i]) begin
            if (!in_order[i].done) begin
                pending.push_back(i);
            end
        end
        if ((pending.size() > 0) && (rand_bits(2) != 0)) begin
            idx            = pending[rand_bits(4) % pending.size()];
            c.valid        = 1'b1;
            c.tag          = in_order[idx].tag;
            c.data         = rand_bits(32);
            // roughly one in sixteen mispredicts
            c.actual_taken = in_order[idx].pred ^ (rand_bits(4) == 0);
            c.target       = rand_bits(32);
        end
        return c;
    endfunction

    task automatic next_cycle();
        @(negedge clk);
        credits += int'(credit_return);
    endtask

    // outputs while reset is held
    a_reset_state: assert property (@(negedge clk)
        rst |-> (!commit.valid && !store_release.valid && !redirect.valid
                 && (credit_return == '0)))
        else report_mismatch("reset_outputs", '0,
                             $sampled({commit.valid, store_release.valid, redirect.valid,
                                       credit_return}));

    a_commit: assert property (@(negedge clk) disable iff (rst)
        (commit.valid == exp_commit.valid) && (!commit.valid || (commit == exp_commit)))
        else report_mismatch("commit", $sampled(exp_commit), $sampled(commit));

    a_store: assert property (@(negedge clk) disable iff (rst)
        (store_release.valid == exp_store.valid)
        && (!store_release.valid || (store_release == exp_store)))
        else report_mismatch("store_release", $sampled(exp_store), $sampled(store_release));

    a_redirect: assert property (@(negedge clk) disable iff (rst)
        (redirect.valid == exp_redirect.valid) && (!redirect.valid || (redirect == exp_redirect)))
        else report_mismatch("redirect", $sampled(exp_redirect), $sampled(redirect));

    a_credit: assert property (@(negedge clk) disable iff (rst) credit_return == exp_credit)
        else report_mismatch("credit_return", $sampled(exp_credit), $sampled(credit_return));

    a_alloc: assert property (@(negedge clk) disable iff (rst) alloc_tag == exp_alloc_tag)
        else report_mismatch("alloc_tag", $sampled(exp_alloc_tag), $sampled(alloc_tag));

    a_src1: assert property (@(negedge clk) disable iff (rst) operand_match(src1, exp_src1))
        else report_mismatch("src1", $sampled(exp_src1), $sampled(src1));

    a_src2: assert property (@(negedge clk) disable iff (rst) operand_match(src2, exp_src2))
        else report_mismatch("src2", $sampled(exp_src2), $sampled(src2));

    // held credits plus the fresh return plus entries in flight
    a_credit_sum: assert property (@(negedge clk) disable iff (rst)
        credits + int'(credit_return) + in_flight == ooo_ctrl_pkg::rob_depth)
        else report_mismatch("credits_plus_in_flight", ooo_ctrl_pkg::rob_depth,
                             $sampled(credits + int'(credit_return) + in_flight));

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles with %0d entries still in flight",
                     cycles, in_flight);
            stop_with_failure();
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        dispatch   = '0;
        complete   = '0;
        dispatched = 0;
        cycles     = 0;
        reset_model();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while ((dispatched < num_instr) || (in_order.size() > 0)) begin
            dispatch = pick_dispatch();
            complete = pick_completion();
            if (dispatch.valid) begin
                credits--;
                dispatched++;
            end
            apply_edge(dispatch, complete);
            next_cycle();
        end
        // one idle edge so the last checks run
        dispatch = '0;
        complete = '0;
        apply_edge(dispatch, complete);
        next_cycle();
        if (credits != ooo_ctrl_pkg::rob_depth) begin
            $display("credits not all returned at the end, %0d held", credits);
            stop_with_failure();
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

//--- hw/ooo_commit_top.sv
`timescale 1ns/10ps

module ooo_commit_top (
    input  logic                          clk,
    input  logic                          rst,
    input  ooo_types_pkg::dispatch_t      dispatch,
    input  ooo_types_pkg::complete_t      complete,
    output ooo_types_pkg::rob_tag_t       alloc_tag,
    output ooo_types_pkg::operand_t       src1,
    output ooo_types_pkg::operand_t       src2,
    output ooo_types_pkg::commit_t        commit,
    output ooo_ctrl_pkg::store_release_t  store_release,
    output ooo_ctrl_pkg::redirect_t       redirect,
    output ooo_ctrl_pkg::credit_t         credit_return
);

    ooo_types_pkg::rob_tag_t look1_tag;
    ooo_types_pkg::rob_tag_t look2_tag;
    logic                    rob1_done;
    logic                    rob2_done;
    ooo_types_pkg::data_t    rob1_data;
    ooo_types_pkg::data_t    rob2_data;
    ooo_types_pkg::data_t    rf1_data;
    ooo_types_pkg::data_t    rf2_data;
    logic                    flush;

    alias_table alias_table_inst (
        .clk       (clk),
        .rst       (rst),
        .dispatch  (dispatch),
        .alloc_tag (alloc_tag),
        .commit    (commit),
        .flush     (flush),
        .rob1_done (rob1_done),
        .rob1_data (rob1_data),
        .rob2_done (rob2_done),
        .rob2_data (rob2_data),
        .rf1_data  (rf1_data),
        .rf2_data  (rf2_data),
        .look1_tag (look1_tag),
        .look2_tag (look2_tag),
        .src1      (src1),
        .src2      (src2)
    );

    reorder_buffer reorder_buffer_inst (
        .clk           (clk),
        .rst           (rst),
        .dispatch      (dispatch),
        .complete      (complete),
        .look1_tag     (look1_tag),
        .look2_tag     (look2_tag),
        .alloc_tag     (alloc_tag),
        .rob1_done     (rob1_done),
        .rob1_data     (rob1_data),
        .rob2_done     (rob2_done),
        .rob2_data     (rob2_data),
        .commit        (commit),
        .store_release (store_release),
        .redirect      (redirect),
        .flush         (flush),
        .credit_return (credit_return)
    );

    arch_regfile arch_regfile_inst (
        .clk      (clk),
        .rst      (rst),
        .commit   (commit),
        .rs1      (dispatch.rs1),
        .rs2      (dispatch.rs2),
        .rf1_data (rf1_data),
        .rf2_data (rf2_data)
    );

endmodule

//--- hw/arch_regfile.sv
`timescale 1ns/10ps

module arch_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  ooo_types_pkg::commit_t  commit,
    input  ooo_types_pkg::reg_idx_t rs1,
    input  ooo_types_pkg::reg_idx_t rs2,
    output ooo_types_pkg::data_t    rf1_data,
    output ooo_types_pkg::data_t    rf2_data
);

    ooo_types_pkg::data_t regs [1:ooo_types_pkg::num_regs-1];

    logic wr_en;

    // x0 commits are dropped here
    assign wr_en = commit.valid && (commit.rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < ooo_types_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[commit.rd] <= commit.data;
        end
    end

    // write-through so a value is readable in its commit cycle
    function automatic ooo_types_pkg::data_t read_reg(input ooo_types_pkg::reg_idx_t idx);
        ooo_types_pkg::data_t value;
        if (idx == '0) begin
            value = '0;
        end else if (wr_en && (commit.rd == idx)) begin
            value = commit.data;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    always_comb begin
        rf1_data = read_reg(rs1);
    end

    always_comb begin
        rf2_data = read_reg(rs2);
    end

endmodule

//--- hw/reorder_buffer.sv
`timescale 1ns/10ps

module reorder_buffer (
    input  logic                          clk,
    input  logic                          rst,
    input  ooo_types_pkg::dispatch_t      dispatch,
    input  ooo_types_pkg::complete_t      complete,
    input  ooo_types_pkg::rob_tag_t       look1_tag,
    input  ooo_types_pkg::rob_tag_t       look2_tag,
    output ooo_types_pkg::rob_tag_t       alloc_tag,
    output logic                          rob1_done,
    output ooo_types_pkg::data_t          rob1_data,
    output logic                          rob2_done,
    output ooo_types_pkg::data_t          rob2_data,
    output ooo_types_pkg::commit_t        commit,
    output ooo_ctrl_pkg::store_release_t  store_release,
    output ooo_ctrl_pkg::redirect_t       redirect,
    output logic                          flush,
    output ooo_ctrl_pkg::credit_t         credit_return
);

    ooo_types_pkg::rob_tag_t head;
    ooo_types_pkg::rob_tag_t tail;
    ooo_ctrl_pkg::credit_t   count;

    ooo_types_pkg::reg_idx_t ent_rd     [ooo_ctrl_pkg::rob_depth];
    logic                    ent_store  [ooo_ctrl_pkg::rob_depth];
    logic                    ent_pred   [ooo_ctrl_pkg::rob_depth];
    logic                    ent_done   [ooo_ctrl_pkg::rob_depth];
    ooo_types_pkg::data_t    ent_data   [ooo_ctrl_pkg::rob_depth];
    logic                    ent_actual [ooo_ctrl_pkg::rob_depth];
    ooo_types_pkg::addr_t    ent_target [ooo_ctrl_pkg::rob_depth];

    logic                    full;
    logic                    empty;
    logic                    do_alloc;
    logic                    do_retire;
    logic                    mispredict;
    logic                    cpl_in_range;
    logic                    cpl_accept;
    ooo_types_pkg::rob_tag_t cpl_offset;

    assign full  = (count == ooo_ctrl_pkg::credit_t'(ooo_ctrl_pkg::rob_depth));
    assign empty = (count == '0);

    // front end only dispatches while it holds a credit
    assign do_alloc  = dispatch.valid;
    assign alloc_tag = tail;

    assign do_retire  = !empty && ent_done[head];
    assign mispredict = do_retire && (ent_pred[head] != ent_actual[head]);
    assign flush      = mispredict;

    // distance from head tells whether the tag is still in flight
    assign cpl_offset   = complete.tag - head;
    assign cpl_in_range = ooo_ctrl_pkg::credit_t'(cpl_offset) < count;
    assign cpl_accept   = complete.valid && cpl_in_range && !ent_done[complete.tag];

    // done stays set after retirement until the slot is reused
    assign rob1_done = ent_done[look1_tag];
    assign rob1_data = ent_data[look1_tag];
    assign rob2_done = ent_done[look2_tag];
    assign rob2_data = ent_data[look2_tag];

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (mispredict) begin
            // branch retires, all younger entries dropped
            head  <= head + 1'b1;
            tail  <= head + 1'b1;
            count <= '0;
        end else begin
            if (do_alloc) begin
                tail <= tail + 1'b1;
            end
            if (do_retire) begin
                head <= head + 1'b1;
            end
            count <= count + ooo_ctrl_pkg::credit_t'(do_alloc)
                           - ooo_ctrl_pkg::credit_t'(do_retire);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ooo_ctrl_pkg::rob_depth; i++) begin
                ent_done[i] <= 1'b0;
            end
        end else begin
            if (do_alloc) begin
                ent_done[tail] <= 1'b0;
            end
            if (cpl_accept) begin
                ent_done[complete.tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_alloc) begin
            ent_rd[tail]    <= dispatch.rd;
            ent_store[tail] <= dispatch.is_store;
            ent_pred[tail]  <= dispatch.pred_taken;
        end
        if (cpl_accept) begin
            ent_data[complete.tag]   <= complete.data;
            ent_actual[complete.tag] <= complete.actual_taken;
            ent_target[complete.tag] <= complete.target;
        end
    end

    // retirement results, visible for one cycle
    always_ff @(posedge clk) begin
        commit.rd            <= ent_rd[head];
        commit.data          <= ent_data[head];
        commit.tag           <= head;
        store_release.tag    <= head;
        redirect.target      <= ent_target[head];
        if (rst) begin
            commit.valid        <= 1'b0;
            store_release.valid <= 1'b0;
            redirect.valid      <= 1'b0;
            credit_return       <= '0;
        end else begin
            commit.valid        <= do_retire && !ent_store[head];
            store_release.valid <= do_retire && ent_store[head];
            redirect.valid      <= mispredict;
            if (mispredict) begin
                // a same-cycle dispatch is flushed too
                credit_return <= count + ooo_ctrl_pkg::credit_t'(do_alloc);
            end else begin
                credit_return <= ooo_ctrl_pkg::credit_t'(do_retire);
            end
        end
    end

    a_no_dispatch_full: assert property (
        @(posedge clk) disable iff (rst) dispatch.valid |-> !full
    ) else $error("dispatch while reorder buffer is full");

    // flushed tags may still report during the redirect cycle
    a_complete_live: assert property (
        @(posedge clk) disable iff (rst)
        (complete.valid && !redirect.valid) |-> (cpl_in_range && !ent_done[complete.tag])
    ) else $error("completion to a free or already done entry");

endmodule

//--- hw/alias_table.sv
`timescale 1ns/10ps

module alias_table (
    input  logic                      clk,
    input  logic                      rst,
    input  ooo_types_pkg::dispatch_t  dispatch,
    input  ooo_types_pkg::rob_tag_t   alloc_tag,
    input  ooo_types_pkg::commit_t    commit,
    input  logic                      flush,
    input  logic                      rob1_done,
    input  ooo_types_pkg::data_t      rob1_data,
    input  logic                      rob2_done,
    input  ooo_types_pkg::data_t      rob2_data,
    input  ooo_types_pkg::data_t      rf1_data,
    input  ooo_types_pkg::data_t      rf2_data,
    output ooo_types_pkg::rob_tag_t   look1_tag,
    output ooo_types_pkg::rob_tag_t   look2_tag,
    output ooo_types_pkg::operand_t   src1,
    output ooo_types_pkg::operand_t   src2
);

    logic [ooo_types_pkg::num_regs-1:0] busy;
    ooo_types_pkg::rob_tag_t            map_tag [ooo_types_pkg::num_regs];

    logic map_write;

    function automatic ooo_types_pkg::operand_t resolve(
        input logic                    mapped,
        input ooo_types_pkg::rob_tag_t tag,
        input logic                    done,
        input ooo_types_pkg::data_t    rob_data,
        input ooo_types_pkg::data_t    rf_data
    );
        ooo_types_pkg::operand_t op;
        op.tag = tag;
        if (!mapped) begin
            op.ready = 1'b1;
            op.value = rf_data;
        end else if (done) begin
            op.ready = 1'b1;
            op.value = rob_data;
        end else begin
            op.ready = 1'b0;
            op.value = '0;
        end
        return op;
    endfunction

    // x0 never gets a producer
    assign map_write = dispatch.valid && (dispatch.rd != '0) && !flush;

    assign look1_tag = map_tag[dispatch.rs1];
    assign look2_tag = map_tag[dispatch.rs2];

    assign src1 = resolve(busy[dispatch.rs1], look1_tag, rob1_done, rob1_data, rf1_data);
    assign src2 = resolve(busy[dispatch.rs2], look2_tag, rob2_done, rob2_data, rf2_data);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= '0;
        end else begin
            // only the youngest producer may release the register
            if (commit.valid && busy[commit.rd] && (map_tag[commit.rd] == commit.tag)) begin
                busy[commit.rd] <= 1'b0;
            end
            if (map_write) begin
                busy[dispatch.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (map_write) begin
            map_tag[dispatch.rd] <= alloc_tag;
        end
    end

endmodule

//--- hw/ooo_ctrl_pkg.sv
package ooo_ctrl_pkg;

    // one entry per tag value
    localparam int rob_depth = 2 ** ooo_types_pkg::rob_tag_w;

    // must hold 0 .. rob_depth
    localparam int credit_w = $clog2(rob_depth + 1);

    typedef logic [credit_w-1:0] credit_t;

    // pc redirect after a mispredicted branch
    typedef struct packed {
        logic                 valid;
        ooo_types_pkg::addr_t target;
    } redirect_t;

    // store allowed to leave the store buffer
    typedef struct packed {
        logic                    valid;
        ooo_types_pkg::rob_tag_t tag;
    } store_release_t;

endpackage

//--- hw/ooo_types_pkg.sv
package ooo_types_pkg;

    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;
    localparam int num_regs  = 2 ** reg_idx_w;
    localparam int rob_tag_w = 4;

    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [xlen-1:0]      data_t;
    typedef logic [xlen-1:0]      addr_t;
    typedef logic [rob_tag_w-1:0] rob_tag_t;

    // one instruction from the front end
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     is_store;
        logic     pred_taken;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } dispatch_t;

    // result report from an execution unit
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        data_t    data;
        logic     actual_taken;
        addr_t    target;
    } complete_t;

    // resolved source, tag is meaningful while not ready
    typedef struct packed {
        logic     ready;
        rob_tag_t tag;
        data_t    value;
    } operand_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        data_t    data;
        rob_tag_t tag;
    } commit_t;

endpackage
